//--- src/fpu_pkg.sv
// fpu package: operation codes, sequencer states and single-precision field constants
package fpu_pkg;

  // ========================================
  // widths and format fields
  // ========================================
  localparam int FLEN = 32;
  localparam int XLEN = 32;

  localparam int EXP_W    = 8;
  localparam int MAN_W    = 23;
  localparam int EXP_BIAS = 127;

  // biased exponent of an integer with bit 31 set
  localparam int CVT_EXP_TOP = EXP_BIAS + XLEN - 1;

  // normalization shift counter, up to 31 steps
  localparam int CNT_W = 5;

  localparam logic [FLEN-1:0] CANON_NAN = 32'h7FC0_0000;

  // compare select in funct3
  localparam logic [2:0] FUNCT3_FEQ = 3'd2;
  localparam logic [2:0] FUNCT3_FLT = 3'd1;
  localparam logic [2:0] FUNCT3_FLE = 3'd0;

  // ========================================
  // operation and state types
  // ========================================
  // same codes as the core's control decoder
  typedef enum logic [4:0] {
    FP_SGNJ  = 5'd5,
    FP_SGNJN = 5'd6,
    FP_SGNJX = 5'd7,
    FP_MIN   = 5'd8,
    FP_MAX   = 5'd9,
    FP_CVT   = 5'd10,
    FP_CMP   = 5'd11,
    FP_CLASS = 5'd12,
    FP_MV_XW = 5'd17,
    FP_MV_WX = 5'd18
  } fp_op_e;

  typedef enum logic [1:0] {
    CVT_IDLE      = 2'd0,
    CVT_NORMALIZE = 2'd1,
    CVT_ROUND     = 2'd2,
    CVT_FINISH    = 2'd3
  } cvt_state_e;

endpackage

//--- src/norm_counter.sv
// normalization step counter, flags the last possible shift
`timescale 1ns/1ps

module norm_counter (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      clear,
  input  logic                      step,
  output logic [fpu_pkg::CNT_W-1:0] count,
  output logic                      count_last
);
  import fpu_pkg::*;

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (clear) begin
      count <= '0;
    end else if (step) begin
      count <= count + CNT_W'(1);
    end
  end

  // 31 shifts without a leading one, so the operand was zero
  assign count_last = (count == {CNT_W{1'b1}});

endmodule

//--- src/cvt_sequencer.sv
// int-to-float sequencer FSM: load, normalize, round, then a one-cycle done
`timescale 1ns/1ps

module cvt_sequencer (
  input  logic            clk,
  input  logic            rst,
  input  logic            start,
  input  fpu_pkg::fp_op_e op,
  input  logic            msb_set,
  input  logic            count_last,
  output logic            load,
  output logic            shift,
  output logic            round,
  output logic            clear,
  output logic            step,
  output logic            busy,
  output logic            cvt_done
);
  import fpu_pkg::*;

  cvt_state_e state;
  cvt_state_e state_next;
  logic       accept;

  // a start is only taken from idle, others are dropped
  assign accept = start && (op == FP_CVT) && (state == CVT_IDLE);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= CVT_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      CVT_IDLE: begin
        if (accept) begin
          state_next = CVT_NORMALIZE;
        end
      end
      // leading one found, or 31 steps with nothing there
      CVT_NORMALIZE: begin
        if (msb_set || count_last) begin
          state_next = CVT_ROUND;
        end
      end
      CVT_ROUND: begin
        state_next = CVT_FINISH;
      end
      default: begin
        state_next = CVT_IDLE;
      end
    endcase
  end

  assign load  = accept;
  assign clear = accept;

  // no shift once the top bit is in place
  assign shift = (state == CVT_NORMALIZE) && !msb_set && !count_last;
  assign step  = shift;

  assign round    = (state == CVT_ROUND);
  assign cvt_done = (state == CVT_FINISH);
  assign busy     = (state == CVT_NORMALIZE) || (state == CVT_ROUND);

endmodule

//--- src/int_to_float.sv
// int-to-float datapath: magnitude shift, RNE rounding and packing
`timescale 1ns/1ps

module int_to_float (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      cvt_unsigned,
  input  logic [fpu_pkg::XLEN-1:0]  int_operand,
  input  logic                      load,
  input  logic                      shift,
  input  logic                      round,
  input  logic [fpu_pkg::CNT_W-1:0] count,
  output logic                      msb_set,
  output logic [fpu_pkg::FLEN-1:0]  cvt_result,
  output logic                      cvt_nx
);
  import fpu_pkg::*;

  logic             in_neg;
  logic             sign_q;
  logic [XLEN-1:0]  mag_q;

  logic             guard;
  logic             sticky;
  logic             round_up;
  logic [MAN_W+1:0] sum;
  logic [EXP_W-1:0] exp_val;
  logic [MAN_W-1:0] man_val;
  logic             is_zero;

  assign in_neg = !cvt_unsigned && int_operand[XLEN-1];

  // ========================================
  // magnitude register
  // ========================================
  // -2^31 negates to itself, which reads correctly as unsigned
  always_ff @(posedge clk) begin
    if (load) begin
      sign_q <= in_neg;
      mag_q  <= in_neg ? -int_operand : int_operand;
    end else if (shift) begin
      mag_q <= mag_q << 1;
    end
  end

  assign msb_set = mag_q[XLEN-1];
  assign is_zero = (mag_q == '0);

  // ========================================
  // round to nearest even
  // ========================================
  // hidden bit plus 23 kept, then guard, then sticky over the rest
  assign guard    = mag_q[XLEN-MAN_W-2];
  assign sticky   = |mag_q[XLEN-MAN_W-3:0];
  assign round_up = guard && (sticky || mag_q[XLEN-MAN_W-1]);

  assign sum = {1'b0, mag_q[XLEN-1 -: MAN_W+1]} + (MAN_W+2)'(round_up);

  // carry out of the significand bumps the exponent
  assign exp_val = EXP_W'(CVT_EXP_TOP) - EXP_W'(count) + EXP_W'(sum[MAN_W+1]);

  // a carry leaves the stored fraction all zero
  assign man_val = sum[MAN_W-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      cvt_result <= '0;
      cvt_nx     <= 1'b0;
    end else if (round) begin
      cvt_result <= is_zero ? '0 : {sign_q, exp_val, man_val};
      cvt_nx     <= |mag_q[XLEN-MAN_W-2:0];
    end
  end

endmodule

//--- src/fp_compare.sv
// compare and classify unit: FEQ/FLT/FLE, FMIN/FMAX and FCLASS
`timescale 1ns/1ps

module fp_compare (
  input  logic [fpu_pkg::FLEN-1:0] operand_a,
  input  logic [fpu_pkg::FLEN-1:0] operand_b,
  input  fpu_pkg::fp_op_e          op,
  input  logic [2:0]               funct3,
  output logic [fpu_pkg::XLEN-1:0] cmp_result,
  output logic [fpu_pkg::XLEN-1:0] class_result,
  output logic [fpu_pkg::FLEN-1:0] minmax_result,
  output logic                     cmp_nv
);
  import fpu_pkg::*;

  // {nan, snan, zero, subnormal, inf}
  function automatic logic [4:0] classify(input logic [FLEN-1:0] x);
    logic exp_ones;
    logic exp_zero;
    logic man_zero;
    exp_ones = &x[FLEN-2 -: EXP_W];
    exp_zero = ~|x[FLEN-2 -: EXP_W];
    man_zero = ~|x[MAN_W-1:0];
    return {exp_ones && !man_zero,
            exp_ones && !man_zero && !x[MAN_W-1],
            exp_zero && man_zero,
            exp_zero && !man_zero,
            exp_ones && man_zero};
  endfunction

  logic a_nan, a_snan, a_zero, a_sub, a_inf, a_norm;
  logic b_nan, b_snan, b_zero;
  logic [4:0] b_class;
  logic a_sign, b_sign;
  logic any_nan, any_snan;
  logic lt_total, lt, eq;
  logic [9:0] class_mask;

  assign {a_nan, a_snan, a_zero, a_sub, a_inf} = classify(operand_a);

  assign b_class = classify(operand_b);
  assign b_nan   = b_class[4];
  assign b_snan  = b_class[3];
  assign b_zero  = b_class[2];

  assign a_sign   = operand_a[FLEN-1];
  assign b_sign   = operand_b[FLEN-1];
  assign a_norm   = !(a_nan || a_zero || a_sub || a_inf);
  assign any_nan  = a_nan || b_nan;
  assign any_snan = a_snan || b_snan;

  // ========================================
  // ordering
  // ========================================
  // sign-magnitude order, -0 below +0
  always_comb begin
    if (a_sign != b_sign) begin
      lt_total = a_sign;
    end else if (a_sign) begin
      lt_total = operand_a[FLEN-2:0] > operand_b[FLEN-2:0];
    end else begin
      lt_total = operand_a[FLEN-2:0] < operand_b[FLEN-2:0];
    end
  end

  // IEEE view, both zeros compare equal
  assign lt = !(a_zero && b_zero) && lt_total;
  assign eq = (a_zero && b_zero) || (operand_a == operand_b);

  always_comb begin
    cmp_result = '0;
    case (funct3)
      FUNCT3_FEQ: cmp_result[0] = !any_nan && eq;
      FUNCT3_FLT: cmp_result[0] = !any_nan && lt;
      FUNCT3_FLE: cmp_result[0] = !any_nan && (lt || eq);
      default:    cmp_result[0] = 1'b0;
    endcase
  end

  // a NaN operand loses to a number
  always_comb begin
    if (a_nan && b_nan) begin
      minmax_result = CANON_NAN;
    end else if (a_nan) begin
      minmax_result = operand_b;
    end else if (b_nan) begin
      minmax_result = operand_a;
    end else if (op == FP_MAX) begin
      minmax_result = lt_total ? operand_b : operand_a;
    end else begin
      minmax_result = lt_total ? operand_a : operand_b;
    end
  end

  always_comb begin
    case (op)
      FP_MIN, FP_MAX: cmp_nv = any_snan;
      FP_CMP:         cmp_nv = (funct3 == FUNCT3_FEQ) ? any_snan : any_nan;
      default:        cmp_nv = 1'b0;
    endcase
  end

  // ========================================
  // fclass mask of operand_a
  // ========================================
  assign class_mask = {a_nan && !a_snan,
                       a_snan,
                       !a_sign && a_inf,
                       !a_sign && a_norm,
                       !a_sign && a_sub,
                       !a_sign && a_zero,
                       a_sign && a_zero,
                       a_sign && a_sub,
                       a_sign && a_norm,
                       a_sign && a_inf};

  assign class_result = {{(XLEN-10){1'b0}}, class_mask};

endmodule

//--- src/fp_result_select.sv
// result selector: sign injection, bit moves, result and flag mux, done
`timescale 1ns/1ps

module fp_result_select (
  input  fpu_pkg::fp_op_e          op,
  input  logic                     start,
  input  logic [fpu_pkg::FLEN-1:0] operand_a,
  input  logic [fpu_pkg::FLEN-1:0] operand_b,
  input  logic [fpu_pkg::XLEN-1:0] int_operand,
  input  logic [fpu_pkg::XLEN-1:0] cmp_result,
  input  logic [fpu_pkg::XLEN-1:0] class_result,
  input  logic [fpu_pkg::FLEN-1:0] minmax_result,
  input  logic                     cmp_nv,
  input  logic [fpu_pkg::FLEN-1:0] cvt_result,
  input  logic                     cvt_nx,
  input  logic                     cvt_done,
  output logic                     done,
  output logic [fpu_pkg::FLEN-1:0] fp_result,
  output logic [fpu_pkg::XLEN-1:0] int_result,
  output logic                     flag_nv,
  output logic                     flag_nx
);
  import fpu_pkg::*;

  logic single_cycle;

  always_comb begin
    case (op)
      FP_SGNJ, FP_SGNJN, FP_SGNJX,
      FP_MIN, FP_MAX, FP_CMP, FP_CLASS,
      FP_MV_XW, FP_MV_WX: single_cycle = 1'b1;
      default:            single_cycle = 1'b0;
    endcase
  end

  // combinational ops finish in their start cycle
  assign done = cvt_done || (start && single_cycle);

  always_comb begin
    fp_result  = '0;
    int_result = '0;
    flag_nv    = 1'b0;
    flag_nx    = 1'b0;
    case (op)
      // sign from operand_b, the rest from operand_a
      FP_SGNJ:  fp_result = {operand_b[FLEN-1], operand_a[FLEN-2:0]};
      FP_SGNJN: fp_result = {~operand_b[FLEN-1], operand_a[FLEN-2:0]};
      FP_SGNJX: fp_result = {operand_a[FLEN-1] ^ operand_b[FLEN-1], operand_a[FLEN-2:0]};
      FP_MIN, FP_MAX: begin
        fp_result = minmax_result;
        flag_nv   = cmp_nv;
      end
      FP_CMP: begin
        int_result = cmp_result;
        flag_nv    = cmp_nv;
      end
      FP_CLASS: int_result = class_result;
      FP_CVT: begin
        fp_result = cvt_result;
        flag_nx   = cvt_nx;
      end
      // raw bit moves between register files
      FP_MV_XW: int_result = operand_a;
      FP_MV_WX: fp_result  = int_operand;
      default: begin
        fp_result  = '0;
        int_result = '0;
      end
    endcase
  end

endmodule

//--- src/fpu_top.sv
// fpu top level: conversion sequencer, counter, datapaths and result selection
`timescale 1ns/1ps

module fpu_top (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      start,
  input  fpu_pkg::fp_op_e           op,
  input  logic [2:0]                funct3,
  input  logic                      cvt_unsigned,
  input  logic [fpu_pkg::FLEN-1:0]  operand_a,
  input  logic [fpu_pkg::FLEN-1:0]  operand_b,
  input  logic [fpu_pkg::XLEN-1:0]  int_operand,
  output logic                      busy,
  output logic                      done,
  output logic [fpu_pkg::FLEN-1:0]  fp_result,
  output logic [fpu_pkg::XLEN-1:0]  int_result,
  output logic                      flag_nv,
  output logic                      flag_nx
);
  import fpu_pkg::*;

  // sequencer strobes
  logic             load;
  logic             shift;
  logic             round;
  logic             clear;
  logic             step;
  logic             cvt_done;

  // status back to the sequencer
  logic             msb_set;
  logic             count_last;
  logic [CNT_W-1:0] count;

  // unit results
  logic [FLEN-1:0]  cvt_result;
  logic             cvt_nx;
  logic [XLEN-1:0]  cmp_result;
  logic [XLEN-1:0]  class_result;
  logic [FLEN-1:0]  minmax_result;
  logic             cmp_nv;

  cvt_sequencer u_cvt_sequencer (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .op         (op),
    .msb_set    (msb_set),
    .count_last (count_last),
    .load       (load),
    .shift      (shift),
    .round      (round),
    .clear      (clear),
    .step       (step),
    .busy       (busy),
    .cvt_done   (cvt_done)
  );

  norm_counter u_norm_counter (
    .clk        (clk),
    .rst        (rst),
    .clear      (clear),
    .step       (step),
    .count      (count),
    .count_last (count_last)
  );

  int_to_float u_int_to_float (
    .clk          (clk),
    .rst          (rst),
    .cvt_unsigned (cvt_unsigned),
    .int_operand  (int_operand),
    .load         (load),
    .shift        (shift),
    .round        (round),
    .count        (count),
    .msb_set      (msb_set),
    .cvt_result   (cvt_result),
    .cvt_nx       (cvt_nx)
  );

  fp_compare u_fp_compare (
    .operand_a     (operand_a),
    .operand_b     (operand_b),
    .op            (op),
    .funct3        (funct3),
    .cmp_result    (cmp_result),
    .class_result  (class_result),
    .minmax_result (minmax_result),
    .cmp_nv        (cmp_nv)
  );

  fp_result_select u_fp_result_select (
    .op            (op),
    .start         (start),
    .operand_a     (operand_a),
    .operand_b     (operand_b),
    .int_operand   (int_operand),
    .cmp_result    (cmp_result),
    .class_result  (class_result),
    .minmax_result (minmax_result),
    .cmp_nv        (cmp_nv),
    .cvt_result    (cvt_result),
    .cvt_nx        (cvt_nx),
    .cvt_done      (cvt_done),
    .done          (done),
    .fp_result     (fp_result),
    .int_result    (int_result),
    .flag_nv       (flag_nv),
    .flag_nx       (flag_nx)
  );

endmodule

//--- dv/fpu_ref.svh
// reference model of the single-precision rules used to predict FPU results
`ifndef FPU_REF_SVH
`define FPU_REF_SVH

function automatic logic ref_is_nan(input logic [31:0] x);
  return (x[30:23] == 8'hFF) && (x[22:0] != 23'd0);
endfunction

function automatic logic ref_is_snan(input logic [31:0] x);
  return ref_is_nan(x) && !x[22];
endfunction

function automatic logic ref_is_zero(input logic [31:0] x);
  return x[30:0] == 31'd0;
endfunction

// unsigned key that sorts like the real line, -0 just below +0
function automatic logic [31:0] order_key(input logic [31:0] x);
  return x[31] ? ~x : (x | 32'h8000_0000);
endfunction

function automatic logic [31:0] ref_sign_inject(input logic [31:0] a, input logic [31:0] b,
                                               input fp_op_e kind);
  logic s;
  case (kind)
    FP_SGNJN: s = !b[31];
    FP_SGNJX: s = a[31] != b[31];
    default:  s = b[31];
  endcase
  return {s, a[30:0]};
endfunction

function automatic logic [9:0] ref_fclass(input logic [31:0] x);
  int idx;
  if (ref_is_nan(x)) idx = x[22] ? 9 : 8;
  else if (x[30:23] == 8'hFF) idx = x[31] ? 0 : 7;
  else if (x[30:23] != 8'h00) idx = x[31] ? 1 : 6;
  else if (x[22:0] != 23'd0) idx = x[31] ? 2 : 5;
  else idx = x[31] ? 3 : 4;
  return 10'(1) << idx;
endfunction

function automatic void ref_compare(input logic [31:0] a, input logic [31:0] b,
                                    input logic [2:0] f3, output logic res, output logic nv);
  logic both_zero;
  logic unordered;
  logic lt;
  logic eq;
  both_zero = ref_is_zero(a) && ref_is_zero(b);
  unordered = ref_is_nan(a) || ref_is_nan(b);
  lt        = !both_zero && (order_key(a) < order_key(b));
  eq        = both_zero || (a == b);
  res       = 1'b0;
  nv        = unordered;
  case (f3)
    FUNCT3_FEQ: begin
      res = !unordered && eq;
      nv  = ref_is_snan(a) || ref_is_snan(b);
    end
    FUNCT3_FLT: res = !unordered && lt;
    FUNCT3_FLE: res = !unordered && (lt || eq);
    default:    res = 1'b0;
  endcase
endfunction

function automatic logic [31:0] ref_minmax(input logic [31:0] a, input logic [31:0] b,
                                          input logic want_max);
  logic a_less;
  if (ref_is_nan(a) && ref_is_nan(b)) return CANON_NAN;
  if (ref_is_nan(a)) return b;
  if (ref_is_nan(b)) return a;
  a_less = order_key(a) < order_key(b);
  return (a_less ^ want_max) ? a : b;
endfunction

// leading one position, then round the dropped tail to nearest even
function automatic void ref_int_to_float(input logic [31:0] v, input logic uns,
                                         output logic [31:0] res, output logic nx);
  logic        sign;
  logic [31:0] mag;
  logic [31:0] mant;
  logic [31:0] rem;
  logic [31:0] half;
  int          top;
  int          sh;
  sign = !uns && v[31];
  mag  = sign ? (~v + 32'd1) : v;
  res  = 32'd0;
  nx   = 1'b0;
  if (mag == 32'd0) return;
  top = 31;
  while (!mag[top]) top--;
  if (top <= 23) begin
    mant = mag << (23 - top);
  end else begin
    sh   = top - 23;
    mant = mag >> sh;
    rem  = mag & ((32'd1 << sh) - 32'd1);
    half = 32'd1 << (sh - 1);
    nx   = rem != 32'd0;
    if (rem > half || (rem == half && mant[0])) mant = mant + 32'd1;
    // rounding carried into a new leading bit
    if (mant[24]) begin
      mant = mant >> 1;
      top  = top + 1;
    end
  end
  res = {sign, 8'(127 + top), mant[22:0]};
endfunction

`endif

//--- dv/fpu_tb.sv
// testbench for the FPU: directed and random operations checked against a reference model
`timescale 1ns/1ps

module fpu_tb;
  import fpu_pkg::*;

  `include "fpu_ref.svh"

  logic        clk = 1'b0;
  logic        rst;
  logic        start;
  fp_op_e      op;
  logic [2:0]  funct3;
  logic        cvt_unsigned;
  logic [31:0] operand_a;
  logic [31:0] operand_b;
  logic [31:0] int_operand;
  logic        busy;
  logic        done;
  logic [31:0] fp_result;
  logic [31:0] int_result;
  logic        flag_nv;
  logic        flag_nx;

  // expectation for the operation in flight
  string       test_name;
  logic        done_exp;
  logic [31:0] exp_fp;
  logic [31:0] exp_int;
  logic        exp_nv;
  logic        exp_nx;

  // zeros, infinities, NaNs of both kinds, subnormals and a few normals
  logic [31:0] specials [12] = '{32'h0000_0000, 32'h8000_0000, 32'h7F80_0000, 32'hFF80_0000,
                                 32'h7FC0_0000, 32'h7F80_0001, 32'hFFC0_0001, 32'hFFA0_0000,
                                 32'h0000_0001, 32'h807F_FFFF, 32'h3F80_0000, 32'hC000_0000};

  fpu_top dut_i (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .op           (op),
    .funct3       (funct3),
    .cvt_unsigned (cvt_unsigned),
    .operand_a    (operand_a),
    .operand_b    (operand_b),
    .int_operand  (int_operand),
    .busy         (busy),
    .done         (done),
    .fp_result    (fp_result),
    .int_result   (int_result),
    .flag_nv      (flag_nv),
    .flag_nx      (flag_nx)
  );

  always #20 clk = ~clk;

  task automatic stop_on_error();
    $display("Testbench failed");
    $fatal(1);
  endtask

  // ========================================
  // checks on every done cycle
  // ========================================
  fp_result_check: assert property (@(posedge clk) disable iff (rst)
                                    done |-> (fp_result == exp_fp))
    else begin
      $display("Error: %s fp_result expected %h actual %h",
               test_name, $sampled(exp_fp), $sampled(fp_result));
      stop_on_error();
    end

  int_result_check: assert property (@(posedge clk) disable iff (rst)
                                     done |-> (int_result == exp_int))
    else begin
      $display("Error: %s int_result expected %h actual %h",
               test_name, $sampled(exp_int), $sampled(int_result));
      stop_on_error();
    end

  nv_check: assert property (@(posedge clk) disable iff (rst) done |-> (flag_nv == exp_nv))
    else begin
      $display("Error: %s flag_nv expected %b actual %b",
               test_name, $sampled(exp_nv), $sampled(flag_nv));
      stop_on_error();
    end

  nx_check: assert property (@(posedge clk) disable iff (rst) done |-> (flag_nx == exp_nx))
    else begin
      $display("Error: %s flag_nx expected %b actual %b",
               test_name, $sampled(exp_nx), $sampled(flag_nx));
      stop_on_error();
    end

  // no stray or repeated done pulse
  done_expected_check: assert property (@(posedge clk) disable iff (rst) done |-> done_exp)
    else begin
      $display("done pulsed when no result was pending in %s", test_name);
      stop_on_error();
    end

  single_cycle_check: assert property (@(posedge clk) disable iff (rst)
                                       (start && op != FP_CVT) |-> (done && !busy))
    else begin
      $display("single-cycle op did not finish in its start cycle in %s", test_name);
      stop_on_error();
    end

  // ========================================
  // stimulus tasks
  // ========================================
  function automatic logic [31:0] pick_operand();
    if ($urandom() % 2 == 0) return specials[4'($urandom() % 12)];
    return $urandom();
  endfunction

  task automatic run_single(input string name, input fp_op_e op_v, input logic [2:0] f3,
                            input logic [31:0] a, input logic [31:0] b, input logic [31:0] iv,
                            input logic [31:0] e_fp, input logic [31:0] e_int,
                            input logic e_nv);
    @(posedge clk);
    start       <= 1'b1;
    op          <= op_v;
    funct3      <= f3;
    operand_a   <= a;
    operand_b   <= b;
    int_operand <= iv;
    test_name   <= name;
    exp_fp      <= e_fp;
    exp_int     <= e_int;
    exp_nv      <= e_nv;
    exp_nx      <= 1'b0;
    done_exp    <= 1'b1;
    @(posedge clk);
    start    <= 1'b0;
    done_exp <= 1'b0;
  endtask

  // restart fires a second start two cycles into the conversion
  task automatic run_cvt(input string name, input logic uns, input logic [31:0] v,
                         input logic restart);
    logic [31:0] e_fp;
    logic        e_nx;
    logic        got;
    int          n;
    ref_int_to_float(v, uns, e_fp, e_nx);
    @(posedge clk);
    start        <= 1'b1;
    op           <= FP_CVT;
    cvt_unsigned <= uns;
    int_operand  <= v;
    test_name    <= name;
    exp_fp       <= e_fp;
    exp_int      <= 32'd0;
    exp_nv       <= 1'b0;
    exp_nx       <= e_nx;
    done_exp     <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    n     = 0;
    got   = 1'b0;
    while (!got) begin
      @(negedge clk);
      n++;
      if (done) begin
        got = 1'b1;
        assert (!busy) else begin
          $display("busy still high in the done cycle of %s", name);
          stop_on_error();
        end
      end else if (n >= 50) begin
        $display("Timeout: no done pulse within 50 cycles in %s", name);
        stop_on_error();
      end else begin
        assert (busy) else begin
          $display("busy went low before done in %s", name);
          stop_on_error();
        end
        @(posedge clk);
        start <= restart && (n == 2);
      end
    end
    assert (n >= 3 && n <= 34) else begin
      $display("conversion took %0d cycles in %s, outside 3 to 34", n, name);
      stop_on_error();
    end
    @(posedge clk);
    done_exp <= 1'b0;
  endtask

  // ========================================
  // test sequence
  // ========================================
  initial begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] iv;
    logic        res;
    logic        nv;
    logic [2:0]  f3_list [3];
    void'($urandom(32'h23551639));
    f3_list      = '{FUNCT3_FEQ, FUNCT3_FLT, FUNCT3_FLE};
    rst          = 1'b1;
    start        = 1'b0;
    op           = FP_SGNJ;
    funct3       = 3'd0;
    cvt_unsigned = 1'b0;
    operand_a    = 32'd0;
    operand_b    = 32'd0;
    int_operand  = 32'd0;
    test_name    = "reset";
    done_exp     = 1'b0;
    exp_fp       = 32'd0;
    exp_int      = 32'd0;
    exp_nv       = 1'b0;
    exp_nx       = 1'b0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    assert (!busy && !done) else begin
      $display("busy or done high right after reset");
      stop_on_error();
    end

    // sign injection and bit moves
    for (int i = 0; i < 40; i++) begin
      a  = pick_operand();
      b  = pick_operand();
      iv = $urandom();
      run_single("fsgnj", FP_SGNJ, 3'd0, a, b, iv, ref_sign_inject(a, b, FP_SGNJ), 32'd0, 1'b0);
      run_single("fsgnjn", FP_SGNJN, 3'd0, a, b, iv, ref_sign_inject(a, b, FP_SGNJN), 32'd0,
                 1'b0);
      run_single("fsgnjx", FP_SGNJX, 3'd0, a, b, iv, ref_sign_inject(a, b, FP_SGNJX), 32'd0,
                 1'b0);
      run_single("fmv_x_w", FP_MV_XW, 3'd0, a, b, iv, 32'd0, a, 1'b0);
      run_single("fmv_w_x", FP_MV_WX, 3'd0, a, b, iv, iv, 32'd0, 1'b0);
    end

    // compares and min/max, sometimes on equal or sign-flipped pairs
    for (int i = 0; i < 60; i++) begin
      a = pick_operand();
      case (i % 4)
        0:       b = a;
        1:       b = {~a[31], a[30:0]};
        default: b = pick_operand();
      endcase
      for (int k = 0; k < 3; k++) begin
        ref_compare(a, b, f3_list[k], res, nv);
        run_single("fcmp", FP_CMP, f3_list[k], a, b, 32'd0, 32'd0, {31'd0, res}, nv);
      end
      nv = ref_is_snan(a) || ref_is_snan(b);
      run_single("fmin", FP_MIN, 3'd0, a, b, 32'd0, ref_minmax(a, b, 1'b0), 32'd0, nv);
      run_single("fmax", FP_MAX, 3'd0, a, b, 32'd0, ref_minmax(a, b, 1'b1), 32'd0, nv);
    end

    // every special class, then random patterns
    for (int i = 0; i < 40; i++) begin
      a = (i < 12) ? specials[i] : $urandom();
      run_single("fclass", FP_CLASS, 3'd0, a, 32'd0, 32'd0, 32'd0, {22'd0, ref_fclass(a)}, 1'b0);
    end

    run_cvt("fcvt_s_w zero", 1'b0, 32'd0, 1'b0);
    run_cvt("fcvt_s_w most negative", 1'b0, 32'h8000_0000, 1'b0);
    run_cvt("fcvt_s_wu all ones", 1'b1, 32'hFFFF_FFFF, 1'b0);
    run_cvt("fcvt_s_w tie to even", 1'b0, 32'h0100_0001, 1'b0);
    run_cvt("fcvt_s_w tie to odd", 1'b0, 32'h0100_0003, 1'b0);
    run_cvt("fcvt_s_w second start", 1'b0, 32'd1, 1'b1);
    for (int i = 0; i < 30; i++) begin
      iv = $urandom() >> ($urandom() % 32);
      run_cvt("fcvt random", 1'($urandom() % 2), iv, 1'b0);
    end

    // idle cycles so a late extra done would still be caught
    repeat (4) @(posedge clk);
    $display("Testbench passed");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+dv
src/fpu_pkg.sv
src/norm_counter.sv
src/cvt_sequencer.sv
src/int_to_float.sv
src/fp_compare.sv
src/fp_result_select.sv
src/fpu_top.sv
dv/fpu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the FPU testbench with Verilator, run it and scan the log for failure
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module fpu_tb -f verilog.f -o fpu_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/fpu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Testbench failed" "$LOG"; then
  echo "simulation reported failure"
  exit 1
fi

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

exit 0
